// ==== src/c64_loader_pkg.sv ====
/*
 * Shared types and constants for the PRG loader: bus widths, the BASIC
 * pointer locations in the zero page and the limits of the post-load sweep
 */
`default_nettype none

package c64_loader_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;

	// ========================================================================
	// BASIC pointers that LOAD leaves behind
	// ========================================================================

	// Start of BASIC text, same as after a cold start
	localparam addr_t PTR_TXT_LO = 16'h002B;
	localparam addr_t PTR_TXT_HI = 16'h002C;
	localparam byte_t TXT_LO_VAL = 8'h01;
	localparam byte_t TXT_HI_VAL = 8'h08;

	// SAVE start, untouched by LOAD
	localparam addr_t PTR_SAVE_LO = 16'h00AC;
	localparam addr_t PTR_SAVE_HI = 16'h00AD;
	localparam byte_t SAVE_VAL    = 8'h00;

	// VAR, ARY, STR and LOAD_END all point at the end of the program
	localparam int PTR_SET_N = 4;
	typedef addr_t [PTR_SET_N-1:0] ptr_set_t;
	localparam ptr_set_t PTR_END_LO_SET = {16'h00AE, 16'h0031, 16'h002F, 16'h002D};
	localparam ptr_set_t PTR_END_HI_SET = {16'h00AF, 16'h0032, 16'h0030, 16'h002E};

	// First address past the zero page
	localparam addr_t ZP_SWEEP_END = 16'h0100;

	// Load address bytes at the head of a PRG file
	localparam int PRG_HDR_LEN = 2;

endpackage

`default_nettype wire

// ==== src/prg_header_parser.sv ====
/*
 * PRG header parser
 * Picks the little-endian load address off the host stream and turns each
 * later byte into a write request, counting the end address as it goes
 */
`timescale 1ns/1ns
`default_nettype none

module prg_header_parser (
	input  wire logic                  clk_sys,
	input  wire logic                  reset_n,
	input  wire logic                  ioctl_download_i,
	input  wire logic                  ioctl_wr_i,
	input  wire c64_loader_pkg::addr_t ioctl_addr_i,
	input  wire c64_loader_pkg::byte_t ioctl_data_i,
	output logic                       hdr_req_o,
	output c64_loader_pkg::addr_t      hdr_addr_o,
	output c64_loader_pkg::byte_t      hdr_data_o,
	output c64_loader_pkg::addr_t      end_addr_o
);
	import c64_loader_pkg::*;

	logic  host_byte;
	logic  is_header;
	addr_t wr_addr;

	assign host_byte = ioctl_download_i && ioctl_wr_i;
	assign is_header = ioctl_addr_i < addr_t'(PRG_HDR_LEN);

	// Request strobe, one cycle behind the host byte
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_req_o <= 1'b0;
		end else begin
			hdr_req_o <= host_byte && !is_header;
		end
	end

	// ========================================================================
	// Address counters and the outgoing byte
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (host_byte) begin
			if (is_header) begin
				// Offset 0 is the low byte, offset 1 the high byte
				if (ioctl_addr_i[0]) begin
					wr_addr[15:8]    <= ioctl_data_i;
					end_addr_o[15:8] <= ioctl_data_i;
				end else begin
					wr_addr[7:0]    <= ioctl_data_i;
					end_addr_o[7:0] <= ioctl_data_i;
				end
			end else begin
				hdr_addr_o <= wr_addr;
				hdr_data_o <= ioctl_data_i;
				wr_addr    <= wr_addr + 1'b1;
				end_addr_o <= end_addr_o + 1'b1;
			end
		end
	end

	// Host may only strobe bytes inside a download
	a_wr_in_download: assert property (
		@(posedge clk_sys) disable iff (!reset_n)
		ioctl_wr_i |-> ioctl_download_i
	) else $error("host byte strobe outside of a download");

endmodule

`default_nettype wire

// ==== src/basic_ptr_init.sv ====
/*
 * BASIC pointer initializer
 * After a download, walks the zero page and writes the pointers a BASIC
 * LOAD would have set, then flags completion for the autostart
 */
`timescale 1ns/1ns
`default_nettype none

module basic_ptr_init (
	input  wire logic                  clk_sys,
	input  wire logic                  reset_n,
	input  wire logic                  ioctl_download_i,
	input  wire c64_loader_pkg::addr_t end_addr_i,
	input  wire logic                  pending_i,
	output logic                       ptr_req_o,
	output c64_loader_pkg::addr_t      ptr_addr_o,
	output c64_loader_pkg::byte_t      ptr_data_o,
	output logic                       meminit_done_o
);
	import c64_loader_pkg::*;

	logic  download_q;
	logic  sweeping;
	logic  step;
	logic  is_ptr;
	addr_t sweep_addr;
	byte_t ptr_val;

	// Move on only while the write port is idle
	assign step = sweeping && !pending_i && !ptr_req_o;

	// ========================================================================
	// Pointer lookup for the current sweep address
	// ========================================================================
	always_comb begin
		is_ptr  = 1'b1;
		ptr_val = '0;
		case (sweep_addr)
			PTR_TXT_LO:  ptr_val = TXT_LO_VAL;
			PTR_TXT_HI:  ptr_val = TXT_HI_VAL;
			PTR_SAVE_LO: ptr_val = SAVE_VAL;
			PTR_SAVE_HI: ptr_val = SAVE_VAL;
			default:     is_ptr = 1'b0;
		endcase
		// End pointers all take the address past the last loaded byte
		for (int i = 0; i < PTR_SET_N; i++) begin
			if (sweep_addr == PTR_END_LO_SET[i]) begin
				is_ptr  = 1'b1;
				ptr_val = end_addr_i[7:0];
			end
			if (sweep_addr == PTR_END_HI_SET[i]) begin
				is_ptr  = 1'b1;
				ptr_val = end_addr_i[15:8];
			end
		end
	end

	// ========================================================================
	// Sweep control
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			download_q     <= 1'b0;
			sweeping       <= 1'b0;
			sweep_addr     <= '0;
			ptr_req_o      <= 1'b0;
			meminit_done_o <= 1'b0;
		end else begin
			download_q     <= ioctl_download_i;
			ptr_req_o      <= 1'b0;
			meminit_done_o <= 1'b0;
			if (download_q && !ioctl_download_i) begin
				sweeping   <= 1'b1;
				sweep_addr <= '0;
			end else if (step) begin
				if (sweep_addr == ZP_SWEEP_END) begin
					sweeping       <= 1'b0;
					meminit_done_o <= 1'b1;
				end else begin
					// Non-pointer addresses are skipped without a write
					ptr_req_o  <= is_ptr;
					sweep_addr <= sweep_addr + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (step && is_ptr) begin
			ptr_addr_o <= sweep_addr;
			ptr_data_o <= ptr_val;
		end
	end

	// Port slot must be free whenever a pointer write is requested
	a_req_when_free: assert property (
		@(posedge clk_sys) disable iff (!reset_n)
		ptr_req_o |-> !pending_i
	) else $error("pointer request while a write is still pending");

endmodule

`default_nettype wire

// ==== src/mem_write_port.sv ====
/*
 * Memory write port
 * Holds one pending write from either requester and issues it in the
 * next memory slot opened by the falling edge of io_cycle
 */
`timescale 1ns/1ns
`default_nettype none

module mem_write_port (
	input  wire logic                  clk_sys,
	input  wire logic                  reset_n,
	input  wire logic                  hdr_req_i,
	input  wire logic                  ptr_req_i,
	input  wire c64_loader_pkg::addr_t hdr_addr_i,
	input  wire c64_loader_pkg::addr_t ptr_addr_i,
	input  wire c64_loader_pkg::byte_t hdr_data_i,
	input  wire c64_loader_pkg::byte_t ptr_data_i,
	input  wire logic                  io_cycle_i,
	output logic                       pending_o,
	output logic                       mem_we_o,
	output c64_loader_pkg::addr_t      mem_addr_o,
	output c64_loader_pkg::byte_t      mem_data_o
);
	import c64_loader_pkg::*;

	logic  io_cycle_q;
	logic  slot_start;
	logic  slot_end;
	logic  any_req;
	addr_t slot_addr;
	byte_t slot_data;

	// Slot opens on the falling edge, closes after two high cycles
	assign slot_start = io_cycle_q && !io_cycle_i;
	assign slot_end   = io_cycle_q && io_cycle_i;
	assign any_req    = hdr_req_i || ptr_req_i;

	// ========================================================================
	// Pending flag and write window
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_q <= 1'b0;
			pending_o  <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_q <= io_cycle_i;
			if (slot_start && pending_o) begin
				mem_we_o  <= 1'b1;
				pending_o <= 1'b0;
			end else if (slot_end) begin
				mem_we_o <= 1'b0;
			end
			if (any_req) begin
				pending_o <= 1'b1;
			end
		end
	end

	// Held write and the address/data presented to memory
	always_ff @(posedge clk_sys) begin
		if (any_req) begin
			slot_addr <= hdr_req_i ? hdr_addr_i : ptr_addr_i;
			slot_data <= hdr_req_i ? hdr_data_i : ptr_data_i;
		end
		if (slot_start && pending_o) begin
			mem_addr_o <= slot_addr;
			mem_data_o <= slot_data;
		end
	end

	// One requester at a time, and never into an occupied slot
	a_single_req: assert property (
		@(posedge clk_sys) disable iff (!reset_n)
		any_req |-> !(hdr_req_i && ptr_req_i) && !pending_o
	) else $error("write request collides with another or with a pending write");

endmodule

`default_nettype wire

// ==== src/prg_loader_top.sv ====
/*
 * PRG loader top level
 * Header parser, BASIC pointer initializer and memory write port
 */
`timescale 1ns/1ns
`default_nettype none

module prg_loader_top (
	input  wire logic                  clk_sys,
	input  wire logic                  reset_n,
	input  wire logic                  ioctl_download_i,
	input  wire logic                  ioctl_wr_i,
	input  wire c64_loader_pkg::addr_t ioctl_addr_i,
	input  wire c64_loader_pkg::byte_t ioctl_data_i,
	input  wire logic                  io_cycle_i,
	output logic                       ioctl_wait_o,
	output logic                       mem_we_o,
	output c64_loader_pkg::addr_t      mem_addr_o,
	output c64_loader_pkg::byte_t      mem_data_o,
	output logic                       meminit_done_o
);
	import c64_loader_pkg::*;

	logic  hdr_req;
	addr_t hdr_addr;
	byte_t hdr_data;
	logic  ptr_req;
	addr_t ptr_addr;
	byte_t ptr_data;
	addr_t end_addr;
	logic  pending;

	// Host is held off while a write waits for its slot
	assign ioctl_wait_o = pending;

	prg_header_parser u_prg_header_parser (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.hdr_req_o        (hdr_req),
		.hdr_addr_o       (hdr_addr),
		.hdr_data_o       (hdr_data),
		.end_addr_o       (end_addr)
	);

	basic_ptr_init u_basic_ptr_init (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.end_addr_i       (end_addr),
		.pending_i        (pending),
		.ptr_req_o        (ptr_req),
		.ptr_addr_o       (ptr_addr),
		.ptr_data_o       (ptr_data),
		.meminit_done_o   (meminit_done_o)
	);

	mem_write_port u_mem_write_port (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.hdr_req_i  (hdr_req),
		.ptr_req_i  (ptr_req),
		.hdr_addr_i (hdr_addr),
		.ptr_addr_i (ptr_addr),
		.hdr_data_i (hdr_data),
		.ptr_data_i (ptr_data),
		.io_cycle_i (io_cycle_i),
		.pending_o  (pending),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
/*
 * Testbench clock and reset
 * 40 ns system clock, reset held low for the first 4 cycles
 */
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic clk_o,
	output logic reset_n_o
);
	localparam int HALF_PERIOD_NS = 20;
	localparam int RESET_CYCLES   = 4;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD_NS clk_o = ~clk_o;
	end

	initial begin
		reset_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/tb_prg_loader.sv ====
/*
 * PRG loader testbench
 * Streams the PRG files from the test data through the host port, serves
 * memory slots, models memory and checks payload and BASIC pointers
 */
`timescale 1ns/1ns
`default_nettype none

module tb_prg_loader;
	import c64_loader_pkg::*;

	localparam int CLK_NS     = 40;
	localparam int IO_PERIOD  = 8;
	localparam int PTR_WRITES = 12;
	localparam int QUIET_CYC  = 16;

	logic  clk_sys;
	logic  reset_n;
	logic  ioctl_download_i;
	logic  ioctl_wr_i;
	addr_t ioctl_addr_i;
	byte_t ioctl_data_i;
	logic  io_cycle_i;
	logic  ioctl_wait_o;
	logic  mem_we_o;
	addr_t mem_addr_o;
	byte_t mem_data_o;
	logic  meminit_done_o;

	// Test table with the payload bytes of all tests stored back to back
	string       test_name [$];
	int          test_load [$];
	int          test_len [$];
	int          test_end [$];
	int          test_off [$];
	byte_t       payload [$];
	int          total_bytes;
	bit          data_loaded;
	byte_t       mem [0:65535];
	int unsigned lcg_state;
	logic [1:0]  io_div;
	logic        we_prev;
	int          write_count;
	int          done_count;
	string       cur_test;

	clock_gen u_clock_gen (
		.clk_o     (clk_sys),
		.reset_n_o (reset_n)
	);

	prg_loader_top u_prg_loader_top (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.io_cycle_i       (io_cycle_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_o       (mem_data_o),
		.meminit_done_o   (meminit_done_o)
	);

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic byte_t fill_byte(input addr_t a);
		return a[7:0] ^ a[15:8] ^ 8'h5A;
	endfunction

	function automatic bit is_ptr_addr(input addr_t a);
		bit hit;
		hit = (a == PTR_TXT_LO) || (a == PTR_TXT_HI);
		hit = hit || (a == PTR_SAVE_LO) || (a == PTR_SAVE_HI);
		for (int i = 0; i < PTR_SET_N; i++) begin
			hit = hit || (a == PTR_END_LO_SET[i]) || (a == PTR_END_HI_SET[i]);
		end
		return hit;
	endfunction

	task automatic report_error(input string why);
		$display("Error in %s: %s", cur_test, why);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
				cur_test, what, expected, actual);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic fill_memory();
		for (int a = 0; a < 65536; a++) begin
			mem[a] = fill_byte(addr_t'(a));
		end
	endtask

	// ========================================================================
	// Test data file
	// ========================================================================
	task automatic load_testdata();
		int    fd;
		int    n;
		int    b;
		int    load_v;
		int    len_v;
		int    end_v;
		string line;
		string name;
		fd = $fopen("tb/prg_testdata.txt", "r");
		if (fd == 0) begin
			report_error("cannot open tb/prg_testdata.txt");
		end
		total_bytes = 0;
		while ($fgets(line, fd) != 0) begin
			if (line.len() == 0 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%s %h %d %h", name, load_v, len_v, end_v);
			if (n != 4) begin
				continue;
			end
			test_name.push_back(name);
			test_load.push_back(load_v);
			test_len.push_back(len_v);
			test_end.push_back(end_v);
			test_off.push_back(payload.size());
			for (int i = 0; i < len_v; i++) begin
				if ($fscanf(fd, "%h", b) != 1) begin
					report_error("payload byte missing in test data");
				end
				payload.push_back(byte_t'(b));
			end
			total_bytes += len_v + PRG_HDR_LEN;
		end
		$fclose(fd);
		data_loaded = 1'b1;
	endtask

	// Send one host byte and hold off until the write port is free again
	task automatic send_byte(input int offset, input byte_t data, input bit use_gap);
		int gap;
		@(posedge clk_sys);
		ioctl_wr_i   <= 1'b1;
		ioctl_addr_i <= addr_t'(offset);
		ioctl_data_i <= data;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		// Parser and port each add a cycle before wait can rise
		@(posedge clk_sys);
		@(negedge clk_sys);
		while (ioctl_wait_o) begin
			@(negedge clk_sys);
		end
		if (use_gap) begin
			lcg_state = lcg_next(lcg_state);
			gap = int'(lcg_state[17:16]);
			repeat (gap) @(posedge clk_sys);
		end
	endtask

	task automatic run_test(input int t);
		addr_t load;
		addr_t end_exp;
		addr_t a;
		int    len;
		bit    use_gap;
		cur_test = test_name[t];
		load     = addr_t'(test_load[t]);
		end_exp  = addr_t'(test_end[t]);
		len      = test_len[t];
		use_gap  = (t % 2 == 0);
		check_value("end address vs load plus length", addr_t'(test_load[t] + len), end_exp);
		fill_memory();
		write_count = 0;
		done_count  = 0;

		@(posedge clk_sys);
		ioctl_download_i <= 1'b1;
		send_byte(0, load[7:0], use_gap);
		send_byte(1, load[15:8], use_gap);
		for (int i = 0; i < len; i++) begin
			send_byte(i + PRG_HDR_LEN, payload[test_off[t] + i], use_gap);
		end
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;

		do @(negedge clk_sys); while (!meminit_done_o);
		check_value("writes at done pulse", len + PTR_WRITES, write_count);
		repeat (QUIET_CYC) @(negedge clk_sys);
		check_value("done pulses", 1, done_count);
		check_value("total writes", len + PTR_WRITES, write_count);

		for (int i = 0; i < len; i++) begin
			a = addr_t'(load + i);
			check_value($sformatf("payload byte %0d", i), payload[test_off[t] + i], mem[a]);
		end
		// Header bytes must not land around the payload
		a = load - 16'd1;
		check_value("byte below load address", fill_byte(a), mem[a]);
		a = load - 16'd2;
		check_value("second byte below load address", fill_byte(a), mem[a]);
		check_value("byte at end address", fill_byte(end_exp), mem[end_exp]);

		check_value("TXTTAB low", 8'h01, mem[PTR_TXT_LO]);
		check_value("TXTTAB high", 8'h08, mem[PTR_TXT_HI]);
		check_value("SAVE start low", 8'h00, mem[PTR_SAVE_LO]);
		check_value("SAVE start high", 8'h00, mem[PTR_SAVE_HI]);
		for (int i = 0; i < PTR_SET_N; i++) begin
			a = PTR_END_LO_SET[i];
			check_value($sformatf("end pointer 0x%02h", a[7:0]), end_exp[7:0], mem[a]);
			a = PTR_END_HI_SET[i];
			check_value($sformatf("end pointer 0x%02h", a[7:0]), end_exp[15:8], mem[a]);
		end
	endtask

	// io_cycle toggles every 4 clocks
	always @(posedge clk_sys) begin
		io_div <= io_div + 2'd1;
		if (io_div == 2'd3) begin
			io_cycle_i <= ~io_cycle_i;
		end
	end

	// ========================================================================
	// Memory model and bus monitor
	// ========================================================================
	always @(negedge clk_sys) begin
		if (reset_n) begin
			if (ioctl_wr_i && ioctl_wait_o) begin
				report_error("host byte sent while ioctl_wait_o was high");
			end
			if (mem_we_o && !we_prev) begin
				if (mem_addr_o[15:8] == 8'h00 && !is_ptr_addr(mem_addr_o)) begin
					report_error($sformatf("write to zero page 0x%02h outside the pointers",
						mem_addr_o[7:0]));
				end
				mem[mem_addr_o] = mem_data_o;
				write_count++;
			end
			if (meminit_done_o) begin
				done_count++;
			end
		end
		we_prev = mem_we_o;
	end

	initial begin : watchdog
		longint limit_ns;
		wait (data_loaded);
		limit_ns = longint'(total_bytes + 256) * 16 * IO_PERIOD * CLK_NS;
		#(limit_ns);
		report_error("timeout, the DUT did not finish all tests in time");
	end

	initial begin : main_flow
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		io_cycle_i       = 1'b1;
		io_div           = '0;
		we_prev          = 1'b0;
		write_count      = 0;
		done_count       = 0;
		data_loaded      = 1'b0;
		lcg_state        = 32'h06a86184;
		cur_test         = "reset";
		load_testdata();

		wait (reset_n);
		@(negedge clk_sys);
		check_value("ioctl_wait_o after reset", 0, ioctl_wait_o);
		check_value("mem_we_o after reset", 0, mem_we_o);
		check_value("meminit_done_o after reset", 0, meminit_done_o);
		repeat (QUIET_CYC) @(negedge clk_sys);
		check_value("writes before first download", 0, write_count);

		for (int t = 0; t < test_name.size(); t++) begin
			run_test(t);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/prg_testdata.txt ====
# name load_addr(hex) payload_len(dec) end_addr(hex)
# next line: payload bytes in hex, in load order
basic_stub 0801 12 080d
0b 08 0a 00 9e 32 30 36 31 00 00 00
page_cross 10f8 16 1108
a9 00 8d 20 d0 8d 21 d0 a2 00 bd 00 11 9d 00 04
single_byte c000 1 c001
60
back_to_back 2000 20 2014
00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 01 23 45 67
top_wrap fff8 8 0000
f0 e1 d2 c3 b4 a5 96 87

// ==== compile.f ====
src/c64_loader_pkg.sv
src/prg_header_parser.sv
src/basic_ptr_init.sv
src/mem_write_port.sv
src/prg_loader_top.sv
tb/clock_gen.sv
tb/tb_prg_loader.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PRG loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_prg_loader -Mdir obj_dir -o tb_prg_loader -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_prg_loader 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
